// ==== src/dcache_pkg.sv ====
// dcache shared definitions for address fields, tag and line formats and controller states
`default_nettype none

package dcache_pkg;

  localparam int OFFSET_W   = 4;  // byte within a 16-byte line
  localparam int INDEX_W    = 8;
  localparam int TAG_W      = 32 - INDEX_W - OFFSET_W;
  localparam int NUM_SETS   = 1 << INDEX_W;
  localparam int LINE_WORDS = 4;

  typedef logic [31:0]          addr_t;
  typedef logic [31:0]          word_t;
  typedef logic [3:0]           strb_t;
  typedef logic [INDEX_W-1:0]   index_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [TAG_W:0]       cache_tag_t;  // valid bit on top
  typedef logic [1:0]           way_t;

  // word 0 is the lowest address of the line
  typedef word_t [LINE_WORDS-1:0] line_t;
  typedef strb_t [LINE_WORDS-1:0] line_strb_t;  // all zero means read

  typedef enum logic [2:0] {
    INIT,
    IDLE,
    LOOKUP,
    COMPARE,
    MISS_WAIT,
    REFILL,
    RETRY
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/dpsram.sv ====
// dual-port ram with a read port and a byte-write port, both registered
`default_nettype none
`timescale 1ns/1ps

module dpsram #(
  parameter int DATA_WIDTH = 32,
  parameter int DATA_DEPTH = 1024,
  parameter int BYTE_SIZE  = 8
) (
  input  wire                               clk,
  input  wire [$clog2(DATA_DEPTH)-1:0]      addr0_i,
  input  wire                               en0_i,
  output logic [DATA_WIDTH-1:0]             rdata0_o,
  input  wire [$clog2(DATA_DEPTH)-1:0]      addr1_i,
  input  wire                               en1_i,
  input  wire [DATA_WIDTH/BYTE_SIZE-1:0]    we1_i,
  input  wire [DATA_WIDTH-1:0]              wdata1_i,
  output logic [DATA_WIDTH-1:0]             rdata1_o
);

  localparam int NUM_BYTES = DATA_WIDTH / BYTE_SIZE;

  logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];

  always_ff @(posedge clk)
  begin
    if (en0_i)
    begin
      rdata0_o <= mem[addr0_i];
    end
  end

  // read-first on port 1
  always_ff @(posedge clk)
  begin
    if (en1_i)
    begin
      rdata1_o <= mem[addr1_i];
      for (int i = 0; i < NUM_BYTES; i++)
      begin
        if (we1_i[i])
        begin
          mem[addr1_i][i*BYTE_SIZE +: BYTE_SIZE] <= wdata1_i[i*BYTE_SIZE +: BYTE_SIZE];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dcache_sram.sv ====
// dcache storage with per-way tag rams and four skewed data banks
`default_nettype none
`timescale 1ns/1ps

module dcache_sram #(
  parameter int WORD_SIZE = 32  // 32 or 64
) (
  input  wire                             clk,

  input  wire [11:0]                      p_addr_i,
  output logic [3:0][WORD_SIZE-1:0]       p_rdata_o,
  output dcache_pkg::cache_tag_t [3:0]    p_rtag_o,

  input  wire dcache_pkg::way_t           m_way_i,
  input  wire [11:0]                      m_addr_i,
  input  wire dcache_pkg::line_strb_t     m_wstrb_i,
  input  wire dcache_pkg::line_t          m_wdata_i,
  output dcache_pkg::line_t               m_rdata_o,

  input  wire dcache_pkg::index_t         t_addr_i,
  input  wire [3:0]                       t_we_i,
  input  wire dcache_pkg::cache_tag_t     t_wtag_i,
  output dcache_pkg::cache_tag_t [3:0]    t_rtag_o
);

  localparam int OFS   = $clog2(WORD_SIZE / 8);  // bank word offset bits
  localparam int DEPTH = 4096 * 8 / WORD_SIZE;   // 1024 or 512
  localparam int TAG_W = $bits(dcache_pkg::cache_tag_t);

  logic [3:0][WORD_SIZE-1:0] raw_pdata;
  logic [3:0][WORD_SIZE-1:0] raw_mdata;
  dcache_pkg::way_t          m_way_q;
  logic [1:0]                p_sel_q;

  for (genvar w = 0; w < 4; w++)
  begin : g_tag
    logic                   conflict;
    logic                   conflict_q;
    dcache_pkg::cache_tag_t rtag0;
    dcache_pkg::cache_tag_t rtag1;

    assign conflict    = (p_addr_i[11:4] == t_addr_i) && t_we_i[w];
    assign p_rtag_o[w] = conflict_q ? rtag1 : rtag0;
    assign t_rtag_o[w] = rtag1;

    always_ff @(posedge clk)
    begin
      conflict_q <= conflict;
    end

    dpsram #(
      .DATA_WIDTH (TAG_W),
      .DATA_DEPTH (dcache_pkg::NUM_SETS),
      .BYTE_SIZE  (TAG_W)
    ) u_tag (
      .clk      (clk),
      .addr0_i  (p_addr_i[11:4]),
      .en0_i    (!conflict),
      .rdata0_o (rtag0),
      .addr1_i  (t_addr_i),
      .en1_i    (1'b1),
      .we1_i    (t_we_i[w]),
      .wdata1_i (t_wtag_i),
      .rdata1_o (rtag1)
    );
  end

  for (genvar b = 0; b < 4; b++)
  begin : g_bank
    localparam logic [1:0] BI = 2'(b);

    logic [11:OFS]          m_baddr;
    logic [WORD_SIZE/8-1:0] m_strb;
    logic [WORD_SIZE-1:0]   m_wdata;
    logic                   conflict;
    logic                   conflict_q;
    logic [WORD_SIZE-1:0]   rdata0;
    logic [WORD_SIZE-1:0]   rdata1;

    if (WORD_SIZE == 32)
    begin : g_w32
      logic [1:0] wsel;
      assign wsel    = m_way_i - BI;  // word of this way kept in bank b
      assign m_baddr = {m_addr_i[11:4], wsel};
      assign m_strb  = m_wstrb_i[wsel];
      assign m_wdata = m_wdata_i[wsel];
    end
    else
    begin : g_w64
      logic dsel;
      logic own;
      assign dsel    = m_way_i[0] ^ BI[0];
      assign own     = (m_way_i[1] == BI[1]);  // way pair shares two banks
      assign m_baddr = {m_addr_i[11:4], dsel};
      assign m_strb  = {m_wstrb_i[{dsel, 1'b1}], m_wstrb_i[{dsel, 1'b0}]} & {8{own}};
      assign m_wdata = {m_wdata_i[{dsel, 1'b1}], m_wdata_i[{dsel, 1'b0}]};
    end

    assign conflict     = (p_addr_i[11:OFS] == m_baddr);
    assign raw_pdata[b] = conflict_q ? rdata1 : rdata0;
    assign raw_mdata[b] = rdata1;

    always_ff @(posedge clk)
    begin
      conflict_q <= conflict;
    end

    dpsram #(
      .DATA_WIDTH (WORD_SIZE),
      .DATA_DEPTH (DEPTH),
      .BYTE_SIZE  (8)
    ) u_data (
      .clk      (clk),
      .addr0_i  (p_addr_i[11:OFS]),
      .en0_i    (!conflict),
      .rdata0_o (rdata0),
      .addr1_i  (m_baddr),
      .en1_i    (1'b1),
      .we1_i    (m_strb),
      .wdata1_i (m_wdata),
      .rdata1_o (rdata1)
    );
  end

  always_ff @(posedge clk)
  begin
    m_way_q <= m_way_i;
    p_sel_q <= p_addr_i[3:2];
  end

  // undo the skew on both read paths
  for (genvar s = 0; s < 4; s++)
  begin : g_rot
    localparam logic [1:0] SI = 2'(s);

    if (WORD_SIZE == 32)
    begin : g_w32
      logic [1:0] mb;
      logic [1:0] pb;
      assign mb           = m_way_q - SI;  // bank with word s of the line
      assign pb           = SI - p_sel_q;  // bank with way s
      assign m_rdata_o[s] = raw_mdata[mb];
      assign p_rdata_o[s] = raw_pdata[pb];
    end
    else
    begin : g_w64
      logic [1:0] mb;
      logic [1:0] pb;
      assign mb           = {m_way_q[1], m_way_q[0] ^ SI[1]};
      assign pb           = {SI[1], SI[0] ^ p_sel_q[1]};
      assign m_rdata_o[s] = raw_mdata[mb][32*(s%2) +: 32];
      assign p_rdata_o[s] = raw_pdata[pb];
    end
  end

  // line and tag writes never share a cycle
  a_mt_excl: assert property (@(posedge clk) !((|m_wstrb_i) && (|t_we_i)))
    else $error("line write and tag write in the same cycle");

endmodule

`default_nettype wire

// ==== src/step_counter.sv ====
// step counter with load to zero and a saturating terminal flag
`default_nettype none
`timescale 1ns/1ps

module step_counter #(
  parameter int WIDTH = 8
) (
  input  wire              clk,
  input  wire              rst_i,
  input  wire              load_i,
  input  wire              step_i,
  output logic [WIDTH-1:0] count_o,
  output logic             done_o
);

  assign done_o = &count_o;  // all ones

  always_ff @(posedge clk)
  begin
    if (rst_i || load_i)
    begin
      count_o <= '0;
    end
    else if (step_i && !done_o)
    begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/dcache_fsm.sv ====
// dcache controller for tag sweep, lookup, write-through and line refill
`default_nettype none
`timescale 1ns/1ps

module dcache_fsm #(
  parameter int WORD_SIZE = 32
) (
  input  wire                              clk,
  input  wire                              rst_i,
  input  wire                              req_i,
  input  wire                              we_i,
  input  wire dcache_pkg::addr_t           addr_i,
  input  wire dcache_pkg::word_t           wdata_i,
  input  wire dcache_pkg::strb_t           wstrb_i,
  output logic                             valid_o,
  output dcache_pkg::word_t                rdata_o,
  output logic                             busy_o,
  output logic                             mem_req_o,
  output logic                             mem_we_o,
  output dcache_pkg::addr_t                mem_addr_o,
  output dcache_pkg::word_t                mem_wdata_o,
  output dcache_pkg::strb_t                mem_wstrb_o,
  input  wire                              mem_valid_i,
  input  wire dcache_pkg::word_t           mem_rdata_i,
  output logic                             cnt_load_o,
  output logic                             cnt_step_o,
  input  wire dcache_pkg::index_t          cnt_i,
  input  wire                              cnt_done_i,
  output logic [11:0]                      p_addr_o,
  input  wire [3:0][WORD_SIZE-1:0]         p_rdata_i,
  input  wire dcache_pkg::cache_tag_t [3:0] p_rtag_i,
  output dcache_pkg::way_t                 m_way_o,
  output logic [11:0]                      m_addr_o,
  output dcache_pkg::line_strb_t           m_wstrb_o,
  output dcache_pkg::line_t                m_wdata_o,
  output dcache_pkg::index_t               t_addr_o,
  output logic [3:0]                       t_we_o,
  output dcache_pkg::cache_tag_t           t_wtag_o
);

  localparam int TW = dcache_pkg::TAG_W;

  dcache_pkg::ctrl_state_t state_q;
  dcache_pkg::addr_t       req_addr_q;
  logic                    req_we_q;
  dcache_pkg::word_t       req_wdata_q;
  dcache_pkg::strb_t       req_wstrb_q;
  dcache_pkg::way_t        victim_q;
  dcache_pkg::way_t        rr_q;
  dcache_pkg::tag_t        req_tag;
  logic [3:0]              hit;
  logic                    any_hit;
  dcache_pkg::way_t        hit_way;
  dcache_pkg::way_t        victim;
  logic [WORD_SIZE-1:0]    hit_data;
  dcache_pkg::word_t       hit_word;
  dcache_pkg::word_t       fill_word;
  logic                    accept;
  logic                    last_beat;
  logic                    in_compare;

  assign req_tag    = req_addr_q[31:32-TW];
  assign busy_o     = (state_q != dcache_pkg::IDLE) || valid_o;
  assign accept     = req_i && !busy_o;
  assign in_compare = (state_q == dcache_pkg::COMPARE);
  assign last_beat  = mem_valid_i && (cnt_i[1:0] == 2'(dcache_pkg::LINE_WORDS - 1));

  always_comb
  begin
    hit     = '0;
    hit_way = '0;
    victim  = rr_q;
    for (int w = 3; w >= 0; w--)
    begin
      hit[w] = p_rtag_i[w][TW] && (p_rtag_i[w][TW-1:0] == req_tag);
      if (hit[w])
        hit_way = 2'(w);
      if (!p_rtag_i[w][TW])
        victim = 2'(w);  // lowest invalid way wins
    end
  end

  assign any_hit  = |hit;
  assign hit_data = p_rdata_i[hit_way];

  if (WORD_SIZE == 64)
  begin : g_sel64
    assign hit_word = req_addr_q[2] ? hit_data[63:32] : hit_data[31:0];
  end
  else
  begin : g_sel32
    assign hit_word = hit_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_q   <= dcache_pkg::INIT;
      valid_o   <= 1'b0;
      mem_req_o <= 1'b0;
      rr_q      <= '0;
    end
    else
    begin
      valid_o   <= 1'b0;
      mem_req_o <= 1'b0;
      case (state_q)
        dcache_pkg::INIT:
          if (cnt_done_i)
            state_q <= dcache_pkg::IDLE;
        dcache_pkg::IDLE:
          if (accept)
            state_q <= dcache_pkg::LOOKUP;
        dcache_pkg::LOOKUP, dcache_pkg::RETRY:
          state_q <= dcache_pkg::COMPARE;
        dcache_pkg::COMPARE:
          if (req_we_q || any_hit)
          begin
            valid_o <= 1'b1;
            state_q <= dcache_pkg::IDLE;
          end
          else
          begin
            mem_req_o <= 1'b1;
            state_q   <= dcache_pkg::MISS_WAIT;
          end
        dcache_pkg::MISS_WAIT:
          if (last_beat)
            state_q <= dcache_pkg::REFILL;
        dcache_pkg::REFILL:
        begin
          rr_q    <= rr_q + 1'b1;
          state_q <= dcache_pkg::RETRY;
        end
        default:
          state_q <= dcache_pkg::INIT;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_addr_q  <= addr_i;
      req_we_q    <= we_i;
      req_wdata_q <= wdata_i;
      req_wstrb_q <= wstrb_i;
    end
    if (in_compare)
    begin
      rdata_o  <= hit_word;
      victim_q <= victim;
    end
  end

  // write-through, memory sees every store
  assign mem_we_o    = in_compare && req_we_q;
  assign mem_addr_o  = mem_we_o ? req_addr_q : {req_addr_q[31:4], 4'b0};
  assign mem_wdata_o = req_wdata_q;
  assign mem_wstrb_o = req_wstrb_q;

  assign cnt_load_o = in_compare && !req_we_q && !any_hit;
  assign cnt_step_o = (state_q == dcache_pkg::INIT) ||
                      ((state_q == dcache_pkg::MISS_WAIT) && mem_valid_i);

  assign p_addr_o  = req_addr_q[11:0];
  assign m_addr_o  = req_addr_q[11:0];
  assign m_way_o   = in_compare ? hit_way : victim_q;
  assign fill_word = in_compare ? req_wdata_q : mem_rdata_i;
  assign m_wdata_o = {dcache_pkg::LINE_WORDS{fill_word}};

  always_comb
  begin
    m_wstrb_o = '0;
    if (in_compare && req_we_q && any_hit)
      m_wstrb_o[req_addr_q[3:2]] = req_wstrb_q;
    else if ((state_q == dcache_pkg::MISS_WAIT) && mem_valid_i)
      m_wstrb_o[cnt_i[1:0]] = 4'hf;  // one beat per word
  end

  always_comb
  begin
    t_addr_o = req_addr_q[11:4];
    t_we_o   = 4'b0;
    t_wtag_o = {1'b1, req_tag};
    if (state_q == dcache_pkg::INIT)
    begin
      t_addr_o = cnt_i;
      t_we_o   = 4'hf;
      t_wtag_o = '0;  // invalidate every way
    end
    else if (state_q == dcache_pkg::REFILL)
      t_we_o = 4'b1 << victim_q;
  end

  // a line is never held in two ways
  a_one_hit: assert property (@(posedge clk) disable iff (rst_i)
    in_compare |-> $onehot0(hit));

  a_no_valid_init: assert property (@(posedge clk) disable iff (rst_i)
    (state_q == dcache_pkg::INIT) |-> !valid_o);

  a_req_busy: assert property (@(posedge clk) disable iff (rst_i) req_i |-> !busy_o)
    else $error("request while busy ignored");

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
// dcache top joining controller, step counter and storage array
`default_nettype none
`timescale 1ns/1ps

module dcache_top #(
  parameter int WORD_SIZE = 32
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire                    req_i,
  input  wire                    we_i,
  input  wire dcache_pkg::addr_t addr_i,
  input  wire dcache_pkg::word_t wdata_i,
  input  wire dcache_pkg::strb_t wstrb_i,
  output logic                   valid_o,
  output dcache_pkg::word_t      rdata_o,
  output logic                   busy_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output dcache_pkg::addr_t      mem_addr_o,
  output dcache_pkg::word_t      mem_wdata_o,
  output dcache_pkg::strb_t      mem_wstrb_o,
  input  wire                    mem_valid_i,
  input  wire dcache_pkg::word_t mem_rdata_i
);

  logic                         cnt_load;
  logic                         cnt_step;
  dcache_pkg::index_t           cnt;
  logic                         cnt_done;
  logic [11:0]                  p_addr;
  logic [3:0][WORD_SIZE-1:0]    p_rdata;
  dcache_pkg::cache_tag_t [3:0] p_rtag;
  dcache_pkg::way_t             m_way;
  logic [11:0]                  m_addr;
  dcache_pkg::line_strb_t       m_wstrb;
  dcache_pkg::line_t            m_wdata;
  dcache_pkg::index_t           t_addr;
  logic [3:0]                   t_we;
  dcache_pkg::cache_tag_t       t_wtag;

  dcache_fsm #(
    .WORD_SIZE (WORD_SIZE)
  ) u_fsm (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .valid_o     (valid_o),
    .rdata_o     (rdata_o),
    .busy_o      (busy_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_wstrb_o (mem_wstrb_o),
    .mem_valid_i (mem_valid_i),
    .mem_rdata_i (mem_rdata_i),
    .cnt_load_o  (cnt_load),
    .cnt_step_o  (cnt_step),
    .cnt_i       (cnt),
    .cnt_done_i  (cnt_done),
    .p_addr_o    (p_addr),
    .p_rdata_i   (p_rdata),
    .p_rtag_i    (p_rtag),
    .m_way_o     (m_way),
    .m_addr_o    (m_addr),
    .m_wstrb_o   (m_wstrb),
    .m_wdata_o   (m_wdata),
    .t_addr_o    (t_addr),
    .t_we_o      (t_we),
    .t_wtag_o    (t_wtag)
  );

  // sweep count over all sets, low bits count refill beats
  step_counter #(
    .WIDTH (8)
  ) u_cnt (
    .clk     (clk),
    .rst_i   (rst_i),
    .load_i  (cnt_load),
    .step_i  (cnt_step),
    .count_o (cnt),
    .done_o  (cnt_done)
  );

  dcache_sram #(
    .WORD_SIZE (WORD_SIZE)
  ) u_sram (
    .clk       (clk),
    .p_addr_i  (p_addr),
    .p_rdata_o (p_rdata),
    .p_rtag_o  (p_rtag),
    .m_way_i   (m_way),
    .m_addr_i  (m_addr),
    .m_wstrb_i (m_wstrb),
    .m_wdata_i (m_wdata),
    .m_rdata_o (),
    .t_addr_i  (t_addr),
    .t_we_i    (t_we),
    .t_wtag_i  (t_wtag),
    .t_rtag_o  ()
  );

endmodule

`default_nettype wire

// ==== verification/mem_model.sv ====
// behavioral line memory that answers refill requests with four gapped beats
`default_nettype none
`timescale 1ns/1ps

module mem_model (
  input  wire         clk,
  input  wire         req_i,
  input  wire         we_i,
  input  wire  [31:0] addr_i,
  input  wire  [31:0] wdata_i,
  input  wire  [3:0]  wstrb_i,
  output logic        valid_o,
  output logic [31:0] rdata_o
);

  localparam int WORDS = 8192;  // 32 KB, eight tags per set

  logic [31:0] mem [WORDS];
  logic [31:0] rng;
  logic [31:0] base;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  initial
  begin
    valid_o = 1'b0;
    rdata_o = '0;
    rng     = 32'd94;
    for (int i = 0; i < WORDS; i++)
      mem[i] = fill_word(32'(i) << 2);
    forever
    begin
      @(negedge clk);
      if (req_i)
      begin
        base = {addr_i[31:4], 4'h0};
        for (int b = 0; b < 4; b++)
        begin
          rng = xorshift(rng);
          repeat (rng[1:0]) @(negedge clk);  // gap of up to three cycles
          valid_o = 1'b1;
          rdata_o = mem[{base[14:4], 2'(b)}];
          @(negedge clk);
          valid_o = 1'b0;
        end
      end
    end
  end

  // stores land at once
  always @(negedge clk)
  begin
    if (we_i)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wstrb_i[b])
          mem[addr_i[14:2]][8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
// dcache testbench with a stimulus table, golden memory and a hit/miss model
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;

  localparam int NUM_DIRECTED = 23;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
  localparam int OP_LIMIT     = 200;  // cycles allowed per op
  localparam int MEM_WORDS    = 8192;

  logic        clk;
  logic        rst_i;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  wstrb_i;
  logic        valid_o;
  logic [31:0] rdata_o;
  logic        busy_o;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic [3:0]  mem_wstrb_o;
  logic        mem_valid_i;
  logic [31:0] mem_rdata_i;

  int          tab_grp  [NUM_OPS];
  logic        tab_we   [NUM_OPS];
  logic [31:0] tab_addr [NUM_OPS];
  logic [31:0] tab_data [NUM_OPS];
  logic [3:0]  tab_strb [NUM_OPS];
  int          tab_n;

  logic [31:0] golden [MEM_WORDS];
  logic [19:0] way_tag   [256][4];  // expected cache contents
  logic        way_valid [256][4];
  logic [1:0]  rr;
  int          errors;
  int          checks;

  dcache_top #(
    .WORD_SIZE (32)
  ) dut0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .valid_o     (valid_o),
    .rdata_o     (rdata_o),
    .busy_o      (busy_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_wstrb_o (mem_wstrb_o),
    .mem_valid_i (mem_valid_i),
    .mem_rdata_i (mem_rdata_i)
  );

  mem_model mem0 (
    .clk     (clk),
    .req_i   (mem_req_o),
    .we_i    (mem_we_o),
    .addr_i  (mem_addr_o),
    .wdata_i (mem_wdata_o),
    .wstrb_i (mem_wstrb_o),
    .valid_o (mem_valid_i),
    .rdata_o (mem_rdata_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic string group_name(input int g);
    case (g)
      0: return "reset state";
      1: return "first read misses";
      2: return "repeat read hits";
      3: return "masked write hit";
      4: return "write without allocate";
      5: return "eviction in one set";
      default: return "random mix";
    endcase
  endfunction

  task automatic add(input int g, input logic we, input logic [31:0] a,
                     input logic [31:0] d, input logic [3:0] s);
    tab_grp[tab_n]  = g;
    tab_we[tab_n]   = we;
    tab_addr[tab_n] = a;
    tab_data[tab_n] = d;
    tab_strb[tab_n] = s;
    tab_n++;
  endtask

  task automatic build_table();
    logic [31:0] rng;
    logic [31:0] r;
    tab_n = 0;
    add(1, 1'b0, 32'h0000_0040, 32'h0, 4'h0);
    add(1, 1'b0, 32'h0000_0124, 32'h0, 4'h0);
    add(1, 1'b0, 32'h0000_1208, 32'h0, 4'h0);
    add(2, 1'b0, 32'h0000_0044, 32'h0, 4'h0);
    add(2, 1'b0, 32'h0000_004c, 32'h0, 4'h0);
    add(2, 1'b0, 32'h0000_0128, 32'h0, 4'h0);
    add(3, 1'b1, 32'h0000_0048, 32'hdead_beef, 4'h5);
    add(3, 1'b0, 32'h0000_0048, 32'h0, 4'h0);
    add(3, 1'b1, 32'h0000_012c, 32'h0123_4567, 4'hc);
    add(3, 1'b0, 32'h0000_012c, 32'h0, 4'h0);
    add(4, 1'b1, 32'h0000_2300, 32'hcafe_f00d, 4'hf);
    add(4, 1'b0, 32'h0000_2300, 32'h0, 4'h0);
    add(4, 1'b0, 32'h0000_2304, 32'h0, 4'h0);
    for (int t = 0; t < 5; t++)
      add(5, 1'b0, {17'h0, 3'(t), 12'h500}, 32'h0, 4'h0);
    // all five lines again, the evicted one among them
    for (int t = 1; t <= 5; t++)
      add(5, 1'b0, {17'h0, 3'(t % 5), 12'h508}, 32'h0, 4'h0);
    rng = 32'd94;
    for (int k = 0; k < NUM_RANDOM; k++)
    begin
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      // eight tags over four sets
      add(6, r[8:7] == 2'b00, {17'h0, r[2:0], 6'h0, r[4:3], r[6:5], 2'b00}, rng, r[12:9]);
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic count_is(input string what, input int i, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("op %0d at 0x%08h saw %0d %s instead of %0d", i, tab_addr[i], got, what, exp);
    end
  endtask

  function automatic int lookup(input logic [31:0] a);
    int hit;
    hit = -1;
    for (int w = 0; w < 4; w++)
    begin
      if (way_valid[a[11:4]][w] && way_tag[a[11:4]][w] == a[31:12])
        hit = w;
    end
    return hit;
  endfunction

  // lowest invalid way, else the round-robin pointer
  task automatic install(input logic [31:0] a);
    int victim;
    victim = int'(rr);
    for (int w = 3; w >= 0; w--)
    begin
      if (!way_valid[a[11:4]][w])
        victim = w;
    end
    way_valid[a[11:4]][victim] = 1'b1;
    way_tag[a[11:4]][victim]   = a[31:12];
    rr = rr + 2'd1;  // moves on every refill
  endtask

  task automatic run_op(input int i);
    int          cycles;
    int          n_req;
    int          n_we;
    int          way;
    logic [31:0] a;
    logic [12:0] idx;
    a      = tab_addr[i];
    idx    = a[14:2];
    way    = lookup(a);
    cycles = 0;
    n_req  = 0;
    n_we   = 0;
    while (busy_o)
      @(negedge clk);
    req_i   = 1'b1;
    we_i    = tab_we[i];
    addr_i  = a;
    wdata_i = tab_data[i];
    wstrb_i = tab_strb[i];
    do
    begin
      @(negedge clk);
      req_i = 1'b0;
      cycles++;
      if (mem_req_o)
      begin
        n_req++;
        check("mem_addr_o", mem_addr_o, {a[31:4], 4'h0});
      end
      if (mem_we_o)
      begin
        n_we++;
        check("mem_addr_o", mem_addr_o, a);
        check("mem_wdata_o", mem_wdata_o, tab_data[i]);
        check("mem_wstrb_o", 32'(mem_wstrb_o), 32'(tab_strb[i]));
      end
    end
    while (!valid_o && cycles < OP_LIMIT);
    if (!valid_o)
    begin
      errors++;
      $display("op %0d at 0x%08h got no valid_o within %0d cycles", i, a, OP_LIMIT);
    end
    else
    begin
      count_is("memory writes", i, n_we, tab_we[i] ? 1 : 0);
      count_is("line requests", i, n_req, (!tab_we[i] && way < 0) ? 1 : 0);
      if (tab_we[i] || way >= 0)
        count_is("cycles to valid_o", i, cycles, 3);
      if (tab_we[i])
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (tab_strb[i][b])
            golden[idx][8*b +: 8] = tab_data[i][8*b +: 8];
        end
      end
      else
      begin
        check("rdata_o", rdata_o, golden[idx]);
        if (way < 0)
          install(a);
      end
    end
  endtask

  initial
  begin
    int grp_errors;
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    wstrb_i = '0;
    errors  = 0;
    checks  = 0;
    rr      = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      golden[i] = fill_word(32'(i) << 2);
    for (int s = 0; s < 256; s++)
    begin
      for (int w = 0; w < 4; w++)
      begin
        way_valid[s][w] = 1'b0;
        way_tag[s][w]   = '0;
      end
    end
    build_table();
    repeat (16) @(negedge clk);
    rst_i = 1'b0;
    check("busy_o", 32'(busy_o), 32'h1);
    check("valid_o", 32'(valid_o), 32'h0);
    check("mem_req_o", 32'(mem_req_o), 32'h0);
    check("mem_we_o", 32'(mem_we_o), 32'h0);
    $display("test 0 %s: %0d errors", group_name(0), errors);
    grp_errors = errors;
    for (int i = 0; i < NUM_OPS; i++)
    begin
      run_op(i);
      if (i == NUM_OPS - 1 || tab_grp[i + 1] != tab_grp[i])
      begin
        $display("test %0d %s: %0d errors", tab_grp[i], group_name(tab_grp[i]),
                 errors - grp_errors);
        grp_errors = errors;
      end
    end
    $display("%0d ops, %0d checks, %0d errors", NUM_OPS, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // reset, tag sweep and the per-op limit, with some slack
  initial
  begin
    repeat (NUM_OPS * OP_LIMIT + 16 + 256 + 64) @(posedge clk);
    $display("timeout, the run did not finish within its cycle budget");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
src/dcache_pkg.sv
src/dpsram.sv
src/dcache_sram.sv
src/step_counter.sv
src/dcache_fsm.sv
src/dcache_top.sv
verification/mem_model.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the dcache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
exit 1
